// File: verilog/mmu_dispatch_pkg.sv
/*
 * Shared widths, encodings and the page-count size rule for the page allocator dispatcher.
 * Imported by the dispatcher modules and the testbench.
 */
`default_nettype none

package mmu_dispatch_pkg;

    localparam int req_id_width     = 8;
    localparam int page_idx_width   = 16;
    localparam int page_count_width = 4;   // counts 0..15 can arrive
    localparam int fifo_count_width = 7;
    localparam int max_page_count   = 8;

    // block size class a valid request is rounded up to
    typedef enum logic [1:0] {
        size_512,
        size_1k,
        size_2k,
        size_4k
    } size_class_t;

    // same codes on the alloc and free response channels
    typedef enum logic [1:0] {
        fail_none,
        fail_zero,
        fail_over_4kb
    } fail_reason_t;

    typedef enum logic [3:0] {
        st_idle,
        st_free_fetch,
        st_free_check,
        st_free_settle,
        st_alloc_fetch,
        st_alloc_check,
        st_alloc_retry,
        st_alloc_settle,
        st_spin_1,
        st_spin_2
    } dispatch_state_t;

    function automatic size_class_t classify_page_count(
        input logic [page_count_width-1:0] count
    );
        size_class_t cls;
        case (count)
            1:       cls = size_512;
            2:       cls = size_1k;
            3, 4:    cls = size_2k;
            default: cls = size_4k;   // 5..8, bad counts never reach a request
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire

// File: verilog/alloc_lane.sv
/*
 * Allocation lane. Checks the popped alloc request on the check cycle and registers
 * either the fdt request or a fail response. Issue can be held for a mode switch or retried.
 */
`timescale 1ns/100ps
`default_nettype none

module alloc_lane import mmu_dispatch_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [req_id_width-1:0]     req_id,
    input  logic [page_count_width-1:0] page_count,
    input  logic                        check_strobe,
    input  logic                        hold_issue,
    input  logic                        release_issue,
    input  logic                        retry_strobe,
    output logic                        req_invalid,
    output logic                        req_valid,
    output logic [req_id_width-1:0]     req_id_out,
    output size_class_t                 req_size,
    output logic [page_count_width-1:0] req_origin_size,
    output logic                        rsp_write_en,
    output logic [req_id_width-1:0]     rsp_id,
    output logic                        rsp_fail,
    output fail_reason_t                rsp_fail_reason,
    output logic [page_count_width-1:0] rsp_origin_size
);

    logic accept;   // good request on the check cycle
    logic reject;

    // only meaningful while the fifo head is being checked
    assign req_invalid = (page_count == '0)
                      || (page_count > page_count_width'(max_page_count));
    assign accept = check_strobe && !req_invalid;
    assign reject = check_strobe && req_invalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid    <= 1'b0;
            rsp_write_en <= 1'b0;
            rsp_fail     <= 1'b0;
        end else begin
            // release and retry only come for a good held request
            req_valid    <= (accept && !hold_issue) || release_issue || retry_strobe;
            rsp_write_en <= reject;
            rsp_fail     <= reject;
        end
    end

    // fdt request fields stay put so a retry re-sends the same request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_id_out      <= req_id;
            req_size        <= classify_page_count(page_count);
            req_origin_size <= page_count;
        end
        if (reject) begin
            rsp_id          <= req_id;
            rsp_fail_reason <= (page_count == '0) ? fail_zero : fail_over_4kb;
            rsp_origin_size <= page_count;
        end
    end

endmodule

`default_nettype wire

// File: verilog/free_lane.sv
/*
 * Free lane. Checks the popped free request on the check cycle and registers either
 * the or-tree request, page index included, or a fail response.
 */
`timescale 1ns/100ps
`default_nettype none

module free_lane import mmu_dispatch_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [req_id_width-1:0]     req_id,
    input  logic [page_idx_width-1:0]   page_idx,
    input  logic [page_count_width-1:0] page_count,
    input  logic                        check_strobe,
    input  logic                        hold_issue,
    input  logic                        release_issue,
    output logic                        req_invalid,
    output logic                        req_valid,
    output logic [req_id_width-1:0]     req_id_out,
    output logic [page_idx_width-1:0]   req_page_idx_out,
    output size_class_t                 req_size,
    output logic [page_count_width-1:0] req_origin_size,
    output logic                        rsp_write_en,
    output logic [req_id_width-1:0]     rsp_id,
    output logic                        rsp_fail,
    output fail_reason_t                rsp_fail_reason,
    output logic [page_count_width-1:0] rsp_origin_size
);

    logic accept;
    logic reject;

    assign req_invalid = (page_count == '0)
                      || (page_count > page_count_width'(max_page_count));
    assign accept = check_strobe && !req_invalid;
    assign reject = check_strobe && req_invalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid    <= 1'b0;
            rsp_write_en <= 1'b0;
            rsp_fail     <= 1'b0;
        end else begin
            req_valid    <= (accept && !hold_issue) || release_issue;
            rsp_write_en <= reject;   // one-cycle fail response
            rsp_fail     <= reject;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_id_out       <= req_id;
            req_page_idx_out <= page_idx;   // page being returned
            req_size         <= classify_page_count(page_count);
            req_origin_size  <= page_count;
        end
        if (reject) begin
            rsp_id          <= req_id;
            rsp_fail_reason <= (page_count == '0) ? fail_zero : fail_over_4kb;
            rsp_origin_size <= page_count;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dispatch_fsm.sv
/*
 * Dispatch FSM. Picks alloc or free service, pops the request FIFOs and times the
 * check, hold, release and retry strobes to the two lanes.
 */
`timescale 1ns/100ps
`default_nettype none

module dispatch_fsm import mmu_dispatch_pkg::*; #(
    parameter int free_threshold = 64,
    parameter int settle_cycles  = 7
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        alloc_fifo_empty,
    input  logic                        free_fifo_empty,
    input  logic [fifo_count_width-1:0] free_fifo_count,
    input  logic                        fdt_blocked,
    input  logic                        alloc_rsp_almost_full,
    input  logic                        free_rsp_almost_full,
    input  logic                        alloc_invalid,
    input  logic                        free_invalid,
    output logic                        alloc_req_pop,
    output logic                        free_req_pop,
    output logic                        alloc_check,
    output logic                        free_check,
    output logic                        alloc_hold,
    output logic                        free_hold,
    output logic                        alloc_release,
    output logic                        free_release,
    output logic                        alloc_retry
);

    localparam int cnt_width = $clog2(settle_cycles + 1);

    typedef enum logic [1:0] {
        mode_none,
        mode_alloc,
        mode_free
    } mode_t;

    dispatch_state_t      state, state_next;
    mode_t                last_mode, last_mode_next;
    logic                 to_free, to_free_next;     // switch toward free pending
    logic                 to_alloc, to_alloc_next;   // switch back to alloc pending
    logic [cnt_width-1:0] settle_cnt, settle_cnt_next;
    logic                 alloc_bad, alloc_bad_next; // held alloc request is unusable
    logic                 free_bad, free_bad_next;
    logic                 alloc_stalled;
    logic                 alloc_possible;
    logic                 free_possible;
    logic                 free_backlog;
    logic                 no_work;
    logic                 settle_done;

    assign alloc_stalled  = fdt_blocked || alloc_fifo_empty || alloc_rsp_almost_full;
    assign alloc_possible = (!alloc_fifo_empty || fdt_blocked) && !alloc_rsp_almost_full;
    assign free_possible  = !free_fifo_empty && !free_rsp_almost_full;
    assign free_backlog   = free_fifo_count >= fifo_count_width'(free_threshold);
    assign no_work        = alloc_fifo_empty && !fdt_blocked && free_fifo_empty;
    assign settle_done    = settle_cnt == cnt_width'(settle_cycles - 1);

    assign alloc_req_pop = (state == st_alloc_fetch) && !alloc_stalled;
    assign free_req_pop  = state == st_free_fetch;   // idle already checked free work
    assign alloc_check   = state == st_alloc_check;
    assign free_check    = state == st_free_check;
    assign alloc_hold    = to_alloc;
    assign free_hold     = to_free;
    // release on the last settle cycle so valid lands settle_cycles+1 after check
    assign alloc_release = (state == st_alloc_settle) && settle_done && !alloc_bad;
    assign free_release  = (state == st_free_settle) && settle_done && !free_bad;
    assign alloc_retry   = (state == st_alloc_retry) && fdt_blocked && !to_alloc && !alloc_bad;

    always_comb begin
        state_next      = state;
        last_mode_next  = last_mode;
        to_free_next    = 1'b0;
        to_alloc_next   = 1'b0;
        settle_cnt_next = '0;
        alloc_bad_next  = alloc_bad;
        free_bad_next   = free_bad;

        case (state)
            st_idle: begin
                if (no_work || (alloc_rsp_almost_full && free_rsp_almost_full)) begin
                    state_next = st_spin_1;
                end else if (last_mode == mode_alloc) begin
                    if ((free_backlog && !free_rsp_almost_full)
                        || (alloc_stalled && free_possible)) begin
                        to_free_next = 1'b1;
                        state_next   = st_free_fetch;
                    end else begin
                        state_next = st_alloc_fetch;
                    end
                end else if (last_mode == mode_free) begin
                    if (free_fifo_empty || free_rsp_almost_full) begin
                        to_alloc_next = 1'b1;
                        state_next    = st_alloc_fetch;
                    end else begin
                        state_next = st_free_fetch;
                    end
                end else if (alloc_possible) begin
                    state_next = st_alloc_fetch;   // fresh start prefers alloc
                end else if (free_possible) begin
                    state_next = st_free_fetch;
                end else begin
                    state_next = st_spin_1;
                end
            end
            st_free_fetch: begin
                last_mode_next = mode_free;
                to_free_next   = to_free;
                state_next     = st_free_check;
            end
            st_free_check: begin
                free_bad_next = free_invalid;   // lane result on the head entry
                state_next    = to_free ? st_free_settle : st_idle;
            end
            st_free_settle: begin
                if (settle_done) begin
                    state_next = st_idle;
                end else begin
                    settle_cnt_next = settle_cnt + 1'b1;
                end
            end
            st_alloc_fetch: begin
                last_mode_next = mode_alloc;
                to_alloc_next  = to_alloc;
                state_next     = alloc_stalled ? st_alloc_retry : st_alloc_check;
            end
            st_alloc_check: begin
                alloc_bad_next = alloc_invalid;
                state_next     = to_alloc ? st_alloc_settle : st_idle;
            end
            st_alloc_retry: begin
                // a blocked fdt after a switch still waits out the settle time
                if (fdt_blocked && to_alloc) begin
                    state_next = st_alloc_settle;
                end else begin
                    state_next = st_idle;
                end
            end
            st_alloc_settle: begin
                if (settle_done) begin
                    state_next = st_idle;
                end else begin
                    settle_cnt_next = settle_cnt + 1'b1;
                end
            end
            st_spin_1: state_next = st_spin_2;
            st_spin_2: state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            last_mode  <= mode_none;
            to_free    <= 1'b0;
            to_alloc   <= 1'b0;
            settle_cnt <= '0;
            alloc_bad  <= 1'b1;   // nothing held yet
            free_bad   <= 1'b1;
        end else begin
            state      <= state_next;
            last_mode  <= last_mode_next;
            to_free    <= to_free_next;
            to_alloc   <= to_alloc_next;
            settle_cnt <= settle_cnt_next;
            alloc_bad  <= alloc_bad_next;
            free_bad   <= free_bad_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mmu_dispatcher.sv
/*
 * Page allocator request dispatcher top level. Connects the alloc and free lanes
 * to the dispatch FSM and hands the FSM its threshold and settle parameters.
 */
`timescale 1ns/100ps
`default_nettype none

module mmu_dispatcher import mmu_dispatch_pkg::*; #(
    parameter int free_threshold = 64,
    parameter int settle_cycles  = 7
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // alloc request fifo
    output logic                        alloc_req_pop,
    input  logic [req_id_width-1:0]     alloc_req_id,
    input  logic [page_count_width-1:0] alloc_req_page_count,
    input  logic                        alloc_fifo_empty,
    // free request fifo
    output logic                        free_req_pop,
    input  logic [req_id_width-1:0]     free_req_id,
    input  logic [page_idx_width-1:0]   free_req_page_idx,
    input  logic [page_count_width-1:0] free_req_page_count,
    input  logic                        free_fifo_empty,
    input  logic [fifo_count_width-1:0] free_fifo_count,
    // fdt
    output logic                        alloc_req_valid,
    output logic [req_id_width-1:0]     alloc_req_id_out,
    output size_class_t                 alloc_req_size,
    output logic [page_count_width-1:0] alloc_req_origin_size,
    input  logic                        fdt_blocked,
    // or-tree
    output logic                        free_req_valid,
    output logic [req_id_width-1:0]     free_req_id_out,
    output logic [page_idx_width-1:0]   free_req_page_idx_out,
    output size_class_t                 free_req_size,
    output logic [page_count_width-1:0] free_req_origin_size,
    // alloc response fifo
    output logic                        alloc_rsp_write_en,
    output logic [req_id_width-1:0]     alloc_rsp_id,
    output logic                        alloc_rsp_fail,
    output fail_reason_t                alloc_rsp_fail_reason,
    output logic [page_count_width-1:0] alloc_rsp_origin_size,
    input  logic                        alloc_rsp_almost_full,
    // free response fifo
    output logic                        free_rsp_write_en,
    output logic [req_id_width-1:0]     free_rsp_id,
    output logic                        free_rsp_fail,
    output fail_reason_t                free_rsp_fail_reason,
    output logic [page_count_width-1:0] free_rsp_origin_size,
    input  logic                        free_rsp_almost_full
);

    logic alloc_invalid, free_invalid;
    logic alloc_check, free_check;
    logic alloc_hold, free_hold;
    logic alloc_release, free_release;
    logic alloc_retry;

    alloc_lane u_alloc_lane (
        .clk(clk), .rst_n(rst_n),
        .req_id(alloc_req_id), .page_count(alloc_req_page_count),
        .check_strobe(alloc_check), .hold_issue(alloc_hold),
        .release_issue(alloc_release), .retry_strobe(alloc_retry),
        .req_invalid(alloc_invalid),
        .req_valid(alloc_req_valid), .req_id_out(alloc_req_id_out),
        .req_size(alloc_req_size), .req_origin_size(alloc_req_origin_size),
        .rsp_write_en(alloc_rsp_write_en), .rsp_id(alloc_rsp_id),
        .rsp_fail(alloc_rsp_fail), .rsp_fail_reason(alloc_rsp_fail_reason),
        .rsp_origin_size(alloc_rsp_origin_size)
    );

    free_lane u_free_lane (
        .clk(clk), .rst_n(rst_n),
        .req_id(free_req_id), .page_idx(free_req_page_idx),
        .page_count(free_req_page_count),
        .check_strobe(free_check), .hold_issue(free_hold), .release_issue(free_release),
        .req_invalid(free_invalid),
        .req_valid(free_req_valid), .req_id_out(free_req_id_out),
        .req_page_idx_out(free_req_page_idx_out),
        .req_size(free_req_size), .req_origin_size(free_req_origin_size),
        .rsp_write_en(free_rsp_write_en), .rsp_id(free_rsp_id),
        .rsp_fail(free_rsp_fail), .rsp_fail_reason(free_rsp_fail_reason),
        .rsp_origin_size(free_rsp_origin_size)
    );

    dispatch_fsm #(
        .free_threshold(free_threshold),
        .settle_cycles (settle_cycles)
    ) u_fsm (
        .clk(clk), .rst_n(rst_n),
        .alloc_fifo_empty(alloc_fifo_empty), .free_fifo_empty(free_fifo_empty),
        .free_fifo_count(free_fifo_count), .fdt_blocked(fdt_blocked),
        .alloc_rsp_almost_full(alloc_rsp_almost_full),
        .free_rsp_almost_full(free_rsp_almost_full),
        .alloc_invalid(alloc_invalid), .free_invalid(free_invalid),
        .alloc_req_pop(alloc_req_pop), .free_req_pop(free_req_pop),
        .alloc_check(alloc_check), .free_check(free_check),
        .alloc_hold(alloc_hold), .free_hold(free_hold),
        .alloc_release(alloc_release), .free_release(free_release),
        .alloc_retry(alloc_retry)
    );

endmodule

`default_nettype wire

// File: test/tb_mmu_dispatcher.sv
/*
 * Directed testbench for the dispatcher. Queue models stand in for the two request
 * FIFOs; each test task loads them and checks the lane outputs against the size rules.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mmu_dispatcher import mmu_dispatch_pkg::*; ();

    localparam int free_threshold = 4;
    localparam int settle_cycles  = 7;
    localparam int reset_cycles   = 8;
    localparam int request_count  = 30;   // requests over all tests
    // worst case per request is a switch with settle, doubled for spin gaps
    localparam int timeout_cycles = reset_cycles + 2 * request_count * (settle_cycles + 6) + 100;

    logic clk = 1'b0;
    logic rst_n;
    logic alloc_req_pop, free_req_pop;
    logic [req_id_width-1:0] alloc_req_id, free_req_id;
    logic [page_count_width-1:0] alloc_req_page_count, free_req_page_count;
    logic [page_idx_width-1:0] free_req_page_idx;
    logic alloc_fifo_empty, free_fifo_empty;
    logic [fifo_count_width-1:0] free_fifo_count;
    logic alloc_req_valid, free_req_valid;
    logic [req_id_width-1:0] alloc_req_id_out, free_req_id_out;
    size_class_t alloc_req_size, free_req_size;
    logic [page_count_width-1:0] alloc_req_origin_size, free_req_origin_size;
    logic [page_idx_width-1:0] free_req_page_idx_out;
    logic fdt_blocked;
    logic alloc_rsp_write_en, free_rsp_write_en;
    logic [req_id_width-1:0] alloc_rsp_id, free_rsp_id;
    logic alloc_rsp_fail, free_rsp_fail;
    fail_reason_t alloc_rsp_fail_reason, free_rsp_fail_reason;
    logic [page_count_width-1:0] alloc_rsp_origin_size, free_rsp_origin_size;
    logic alloc_rsp_almost_full, free_rsp_almost_full;

    logic [req_id_width-1:0]     alloc_id_q[$], free_id_q[$];     // fifo contents
    logic [page_count_width-1:0] alloc_cnt_q[$], free_cnt_q[$];
    logic [page_idx_width-1:0]   free_idx_q[$];
    logic [req_id_width-1:0]     alloc_exp_id[$], free_exp_id[$]; // still to be seen
    logic [page_count_width-1:0] alloc_exp_cnt[$], free_exp_cnt[$];
    logic [page_idx_width-1:0]   free_exp_idx[$];
    logic [req_id_width-1:0]     last_alloc_id;
    logic [page_count_width-1:0] last_alloc_cnt;
    logic [31:0] lfsr_state = 32'hb2ea;
    int cycle = 0;

    mmu_dispatcher #(
        .free_threshold(free_threshold),
        .settle_cycles (settle_cycles)
    ) u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > timeout_cycles) begin
            $display("timeout: the dispatcher stopped producing the expected outputs");
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // request fifos, head fields show up the cycle after a pop
    always @(posedge clk) begin
        if ((alloc_req_pop && alloc_id_q.size() == 0)
            || (free_req_pop && free_id_q.size() == 0)) begin
            $display("a request was popped while its FIFO was empty");
            $display("TEST FAILED");
            $fatal(1, "pop on empty FIFO");
        end else begin
            if (alloc_req_pop) begin
                alloc_req_id         <= alloc_id_q[0];
                alloc_req_page_count <= alloc_cnt_q[0];
                void'(alloc_id_q.pop_front());
                void'(alloc_cnt_q.pop_front());
            end
            if (free_req_pop) begin
                free_req_id         <= free_id_q[0];
                free_req_page_idx   <= free_idx_q[0];
                free_req_page_count <= free_cnt_q[0];
                void'(free_id_q.pop_front());
                void'(free_idx_q.pop_front());
                void'(free_cnt_q.pop_front());
            end
            alloc_fifo_empty <= alloc_id_q.size() == 0;
            free_fifo_empty  <= free_id_q.size() == 0;
            free_fifo_count  <= fifo_count_width'(free_id_q.size());
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] random_bits(input int bits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // 512 B pages rounded up to the smallest block that holds them
    function automatic size_class_t expected_size(input int pages);
        int bytes;
        bytes = pages * 512;
        if (bytes <= 512)
            return size_512;
        if (bytes <= 1024)
            return size_1k;
        if (bytes <= 2048)
            return size_2k;
        return size_4k;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s expected %0h actual %0h", test, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // zero time, caller picks the negedge
    task automatic push_alloc(input logic [page_count_width-1:0] cnt);
        logic [req_id_width-1:0] id;
        id = req_id_width'(random_bits(req_id_width));
        alloc_id_q.push_back(id);
        alloc_cnt_q.push_back(cnt);
        alloc_exp_id.push_back(id);
        alloc_exp_cnt.push_back(cnt);
    endtask

    task automatic push_free(input logic [page_count_width-1:0] cnt);
        logic [req_id_width-1:0]   id;
        logic [page_idx_width-1:0] idx;
        id  = req_id_width'(random_bits(req_id_width));
        idx = page_idx_width'(random_bits(page_idx_width));
        free_id_q.push_back(id);
        free_idx_q.push_back(idx);
        free_cnt_q.push_back(cnt);
        free_exp_id.push_back(id);
        free_exp_idx.push_back(idx);
        free_exp_cnt.push_back(cnt);
    endtask

    task automatic check_alloc_fields(input string test);
        last_alloc_id  = alloc_exp_id.pop_front();
        last_alloc_cnt = alloc_exp_cnt.pop_front();
        check_value(test, "alloc id", last_alloc_id, alloc_req_id_out);
        check_value(test, "alloc size", expected_size(last_alloc_cnt), alloc_req_size);
        check_value(test, "alloc origin", last_alloc_cnt, alloc_req_origin_size);
    endtask

    task automatic check_free_fields(input string test);
        logic [page_count_width-1:0] cnt;
        cnt = free_exp_cnt.pop_front();
        check_value(test, "free id", free_exp_id.pop_front(), free_req_id_out);
        check_value(test, "free page idx", free_exp_idx.pop_front(), free_req_page_idx_out);
        check_value(test, "free size", expected_size(cnt), free_req_size);
        check_value(test, "free origin", cnt, free_req_origin_size);
    endtask

    // cycles counted from the pop edge to the issue edge
    task automatic wait_alloc_issue(output int n);
        do @(posedge clk); while (!alloc_req_pop);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!alloc_req_valid);
    endtask

    task automatic wait_free_issue();
        do @(posedge clk); while (!free_req_valid);
    endtask

    task automatic size_classes();
        int n;
        @(negedge clk);
        for (int c = 1; c <= max_page_count; c++) push_alloc(page_count_width'(c));
        for (int c = 1; c <= max_page_count; c++) begin
            wait_alloc_issue(n);
            check_value("size_classes", "pop to issue", 2, n);
            check_alloc_fields("size_classes");
        end
    endtask

    task automatic rejection();
        logic [page_count_width-1:0] bad [3] = '{4'd0, 4'd9, 4'd15};
        @(negedge clk);
        foreach (bad[i]) push_alloc(bad[i]);
        foreach (bad[i]) begin
            do begin
                @(posedge clk);
                check_value("rejection", "alloc_req_valid", 0, alloc_req_valid);
            end while (!alloc_rsp_write_en);
            check_value("rejection", "alloc rsp id", alloc_exp_id.pop_front(), alloc_rsp_id);
            check_value("rejection", "alloc rsp fail", 1, alloc_rsp_fail);
            check_value("rejection", "alloc reason", (bad[i] == 0) ? fail_zero : fail_over_4kb,
                        alloc_rsp_fail_reason);
            check_value("rejection", "alloc rsp origin", alloc_exp_cnt.pop_front(),
                        alloc_rsp_origin_size);
        end
        @(negedge clk);
        foreach (bad[i]) push_free(bad[i]);
        foreach (bad[i]) begin
            do begin
                @(posedge clk);
                check_value("rejection", "free_req_valid", 0, free_req_valid);
            end while (!free_rsp_write_en);
            void'(free_exp_idx.pop_front());
            check_value("rejection", "free rsp id", free_exp_id.pop_front(), free_rsp_id);
            check_value("rejection", "free rsp fail", 1, free_rsp_fail);
            check_value("rejection", "free reason", (bad[i] == 0) ? fail_zero : fail_over_4kb,
                        free_rsp_fail_reason);
            check_value("rejection", "free rsp origin", free_exp_cnt.pop_front(),
                        free_rsp_origin_size);
        end
    endtask

    task automatic free_forwarding();
        @(negedge clk);
        push_free(4'd1);
        push_free(4'd4);
        push_free(4'd8);
        repeat (3) begin
            wait_free_issue();
            check_free_fields("free_forwarding");
        end
    endtask

    task automatic threshold_switch();
        int n;
        @(negedge clk);
        repeat (3) push_alloc(4'd2);
        do @(posedge clk); while (!alloc_req_pop);
        @(negedge clk);   // backlog lands while the first alloc is checked
        for (int i = 0; i < free_threshold; i++) push_free(4'd3);
        do @(posedge clk); while (!alloc_req_valid);
        check_alloc_fields("threshold_switch");
        n = -1;
        do begin
            @(posedge clk);
            check_value("threshold_switch", "alloc_req_valid", 0, alloc_req_valid);
            if (free_req_pop) n = 0;
            else if (n >= 0) n++;
        end while (!free_req_valid);
        check_value("threshold_switch", "pop to free issue", settle_cycles + 2, n);
        check_free_fields("threshold_switch");
        repeat (free_threshold - 1) begin
            wait_free_issue();
            check_free_fields("threshold_switch");
        end
        repeat (2) begin
            wait_alloc_issue(n);
            check_alloc_fields("threshold_switch");
        end
    endtask

    task automatic back_pressure();
        int n;
        @(posedge clk);
        alloc_rsp_almost_full <= 1'b1;
        @(negedge clk);
        push_alloc(4'd5);
        push_alloc(4'd7);
        push_free(4'd2);
        push_free(4'd6);
        repeat (2) begin
            do begin
                @(posedge clk);
                check_value("back_pressure", "alloc_req_pop", 0, alloc_req_pop);
            end while (!free_req_valid);
            check_free_fields("back_pressure");
        end
        repeat (10) begin
            @(posedge clk);
            check_value("back_pressure", "alloc_req_pop", 0, alloc_req_pop);
        end
        alloc_rsp_almost_full <= 1'b0;
        repeat (2) begin
            wait_alloc_issue(n);
            check_alloc_fields("back_pressure");
        end
    endtask

    task automatic blocked_retry();
        @(posedge clk);
        fdt_blocked <= 1'b1;
        repeat (2) begin
            do begin
                @(posedge clk);
                check_value("blocked_retry", "alloc_req_pop", 0, alloc_req_pop);
            end while (!alloc_req_valid);
            check_value("blocked_retry", "alloc id", last_alloc_id, alloc_req_id_out);
            check_value("blocked_retry", "alloc size", expected_size(last_alloc_cnt),
                        alloc_req_size);
            check_value("blocked_retry", "alloc origin", last_alloc_cnt, alloc_req_origin_size);
        end
        fdt_blocked <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    initial begin
        rst_n                 <= 1'b0;
        alloc_req_id          <= '0;
        alloc_req_page_count  <= '0;
        alloc_fifo_empty      <= 1'b1;
        free_req_id           <= '0;
        free_req_page_idx     <= '0;
        free_req_page_count   <= '0;
        free_fifo_empty       <= 1'b1;
        free_fifo_count       <= '0;
        fdt_blocked           <= 1'b0;
        alloc_rsp_almost_full <= 1'b0;
        free_rsp_almost_full  <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        size_classes();
        rejection();
        free_forwarding();
        threshold_switch();
        back_pressure();
        blocked_retry();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/mmu_dispatch_pkg.sv
verilog/alloc_lane.sv
verilog/free_lane.sv
verilog/dispatch_fsm.sv
verilog/mmu_dispatcher.sv
test/tb_mmu_dispatcher.sv

// File: Makefile
# Verilator build and run for the page allocator dispatcher

VERILATOR ?= verilator
TOP       ?= tb_mmu_dispatcher
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
